//--- Bender.yml
package:
  name: stat_collector

sources:
  - files:
      - stat_pkg.sv
      - bit_sync.sv
      - tile_accum.sv
      - xfer_fsm.sv
      - result_capture.sv
      - stat_collector_top.sv
  - target: test
    files:
      - tb_stat_collector.sv

//--- bit_sync.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Level synchronizer for one bit into the clock on clk
// d must hold each level for two or more clk cycles
// Output follows d after SYNC_STAGES clk edges
//----------------------------------------------------------

module bit_sync import stat_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic d,
	output logic q
);

	// d into sync_q[0] is an asynchronous path. Constrain it as a max delay
	// of one destination period and place the chain flops next to each other
	logic [SYNC_STAGES-1:0] sync_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sync_q <= '0;
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], d};
		end
	end

	assign q = sync_q[SYNC_STAGES-1];

	// A new output level must have been held by d on two edges in a row
	a_q_from_d: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(q) && $past(rst_n, SYNC_STAGES) |-> q == $past(d, SYNC_STAGES - 1));

endmodule

//--- list.f
stat_pkg.sv
bit_sync.sv
tile_accum.sv
xfer_fsm.sv
result_capture.sv
stat_collector_top.sv
tb_stat_collector.sv

//--- result_capture.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Destination side of the result transfer, in clk_reg
// snap_* is sampled only on the synchronized rise of req
// A rising test_en_reg clears results and tile_done, not ack
//----------------------------------------------------------

module result_capture import stat_pkg::*; (
	input  logic             clk_reg,
	input  logic             rst_n,
	input  logic             test_en_reg,
	input  logic             req,
	input  logic [ACC_W-1:0] snap_smp,
	input  logic [ACC_W-1:0] snap_err,
	input  logic [ACC_W-1:0] snap_idl,
	input  logic [LAT_W-1:0] snap_lat,
	output logic [ACC_W-1:0] smp_reg,
	output logic [ACC_W-1:0] err_reg,
	output logic [ACC_W-1:0] idl_reg,
	output logic [LAT_W-1:0] lat_reg,
	output logic             tile_done,
	output logic             ack
);

	logic req_s;
	logic en_q;
	logic clr;
	logic load;

	bit_sync req_sync_i (.clk(clk_reg), .rst_n(rst_n), .d(req), .q(req_s));

	assign clr  = test_en_reg & ~en_q;
	assign load = req_s & ~ack;  // ack holds the previous req_s

	always_ff @(posedge clk_reg) begin
		if (!rst_n) begin
			en_q <= 1'b0;
			ack  <= 1'b0;
		end else begin
			en_q <= test_en_reg;
			ack  <= req_s;
		end
	end

	//----------------------------------------------------------
	// Result registers
	//----------------------------------------------------------
	always_ff @(posedge clk_reg) begin
		if (!rst_n || clr) begin
			smp_reg   <= '0;
			err_reg   <= '0;
			idl_reg   <= '0;
			lat_reg   <= '0;
			tile_done <= 1'b0;
		end else if (load) begin
			smp_reg   <= snap_smp;
			err_reg   <= snap_err;
			idl_reg   <= snap_idl;
			lat_reg   <= snap_lat;
			tile_done <= 1'b1;
		end
	end

	a_ack_drops: assert property (@(posedge clk_reg) disable iff (!rst_n)
		!req_s ##1 !req_s |-> !ack);

endmodule

//--- stat_collector_top.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Test statistics collector for NUM_TILES tiles
// Tiles hold vld_aie low from one cycle before done_aie until the next run
// done_stat_reg rises once every tile has delivered its results
//----------------------------------------------------------

module stat_collector_top import stat_pkg::*; (
	// Register side
	input  logic                            clk_reg,
	input  logic                            rst_n,
	input  logic                            test_en_reg,
	output logic [NUM_TILES-1:0][ACC_W-1:0] smp_reg,
	output logic [NUM_TILES-1:0][ACC_W-1:0] err_reg,
	output logic [NUM_TILES-1:0][ACC_W-1:0] idl_reg,
	output logic [NUM_TILES-1:0][LAT_W-1:0] lat_reg,
	output logic                            done_stat_reg,

	// Tile side
	input  logic                            clk_aie,
	input  logic [NUM_TILES-1:0]            vld_aie,
	input  logic [NUM_TILES-1:0][SMP_W-1:0] smp_aie,
	input  logic [NUM_TILES-1:0][SMP_W-1:0] err_aie,
	input  logic [NUM_TILES-1:0][IDL_W-1:0] idl_aie,
	input  logic [NUM_TILES-1:0][LAT_W-1:0] lat_aie,
	input  logic [NUM_TILES-1:0]            done_aie,
	output logic                            test_en_aie
);

	logic                 rst_n_aie;
	logic [NUM_TILES-1:0] tile_done;

	//----------------------------------------------------------
	// Register side to tile side
	//----------------------------------------------------------
	// Reset reaches clk_aie within one edge, release after SYNC_STAGES
	bit_sync rst_sync_i (.clk(clk_aie), .rst_n(rst_n), .d(1'b1), .q(rst_n_aie));

	bit_sync en_sync_i (.clk(clk_aie), .rst_n(rst_n_aie), .d(test_en_reg), .q(test_en_aie));

	//----------------------------------------------------------
	// One result channel per tile
	//----------------------------------------------------------
	for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
		logic [ACC_W-1:0] smp_tot;
		logic [ACC_W-1:0] err_tot;
		logic [ACC_W-1:0] idl_tot;
		logic [LAT_W-1:0] lat_max;
		logic [ACC_W-1:0] snap_smp;
		logic [ACC_W-1:0] snap_err;
		logic [ACC_W-1:0] snap_idl;
		logic [LAT_W-1:0] snap_lat;
		logic             req;
		logic             ack;

		tile_accum accum_i (
			.clk_aie    (clk_aie),
			.rst_n_aie  (rst_n_aie),
			.test_en_aie(test_en_aie),
			.vld        (vld_aie[t]),
			.smp        (smp_aie[t]),
			.err        (err_aie[t]),
			.idl        (idl_aie[t]),
			.lat        (lat_aie[t]),
			.smp_tot    (smp_tot),
			.err_tot    (err_tot),
			.idl_tot    (idl_tot),
			.lat_max    (lat_max)
		);

		xfer_fsm xfer_i (
			.clk_aie  (clk_aie),
			.rst_n_aie(rst_n_aie),
			.done     (done_aie[t]),
			.ack      (ack),
			.smp_tot  (smp_tot),
			.err_tot  (err_tot),
			.idl_tot  (idl_tot),
			.lat_max  (lat_max),
			.snap_smp (snap_smp),
			.snap_err (snap_err),
			.snap_idl (snap_idl),
			.snap_lat (snap_lat),
			.req      (req)
		);

		result_capture capture_i (
			.clk_reg    (clk_reg),
			.rst_n      (rst_n),
			.test_en_reg(test_en_reg),
			.req        (req),
			.snap_smp   (snap_smp),
			.snap_err   (snap_err),
			.snap_idl   (snap_idl),
			.snap_lat   (snap_lat),
			.smp_reg    (smp_reg[t]),
			.err_reg    (err_reg[t]),
			.idl_reg    (idl_reg[t]),
			.lat_reg    (lat_reg[t]),
			.tile_done  (tile_done[t]),
			.ack        (ack)
		);
	end

	always_ff @(posedge clk_reg) begin
		if (!rst_n) begin
			done_stat_reg <= 1'b0;
		end else begin
			done_stat_reg <= &tile_done;  // All tiles reported
		end
	end

endmodule

//--- stat_pkg.sv
//----------------------------------------------------------
// Shared constants for the test statistics collector
// All widths are in bits. SYNC_STAGES must be 2 or more
// ACC_W totals are not saturated and wrap on overflow
//----------------------------------------------------------

package stat_pkg;

	//----------------------------------------------------------
	// Array size
	//----------------------------------------------------------
	localparam int NUM_TILES = 4;

	//----------------------------------------------------------
	// Beat fields, as driven by each tile
	//----------------------------------------------------------
	localparam int SMP_W = 7;   // Sample and error count per beat
	localparam int IDL_W = 12;  // Idle count per beat
	localparam int LAT_W = 16;  // Latency per beat and its maximum

	// Width of every accumulated total
	localparam int ACC_W = 48;

	//----------------------------------------------------------
	// Clock domain crossing
	//----------------------------------------------------------
	// Flops per synchronizer chain, used for enable, reset, req and ack
	localparam int SYNC_STAGES = 4;

endpackage

//--- tb_stat_collector.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Testbench for stat_collector_top, clk_reg 20 ns, clk_aie 14 ns
// Counted beats start the cycle after the tiles see test_en_aie high
//----------------------------------------------------------

module tb_stat_collector import stat_pkg::*; ();

	localparam real AIE_PERIOD = 14.0;
	localparam int  BEATS      = 64;  // Beats per run and tile
	localparam int  NOISE      = 16;  // Beats sent with the enable off
	localparam int  NUM_RUNS   = 2;

	logic                            clk_reg;
	logic                            clk_aie;
	logic                            rst_n;
	logic                            test_en_reg;
	logic [NUM_TILES-1:0][ACC_W-1:0] smp_reg;
	logic [NUM_TILES-1:0][ACC_W-1:0] err_reg;
	logic [NUM_TILES-1:0][ACC_W-1:0] idl_reg;
	logic [NUM_TILES-1:0][LAT_W-1:0] lat_reg;
	logic                            done_stat_reg;
	logic [NUM_TILES-1:0]            vld_aie;
	logic [NUM_TILES-1:0][SMP_W-1:0] smp_aie;
	logic [NUM_TILES-1:0][SMP_W-1:0] err_aie;
	logic [NUM_TILES-1:0][IDL_W-1:0] idl_aie;
	logic [NUM_TILES-1:0][LAT_W-1:0] lat_aie;
	logic [NUM_TILES-1:0]            done_aie;
	logic                            test_en_aie;

	// Reference model sums and the values the register side should show
	logic [ACC_W-1:0] sum_smp [NUM_TILES];
	logic [ACC_W-1:0] sum_err [NUM_TILES];
	logic [ACC_W-1:0] sum_idl [NUM_TILES];
	logic [LAT_W-1:0] sum_lat [NUM_TILES];
	logic [ACC_W-1:0] exp_smp [NUM_TILES];
	logic [ACC_W-1:0] exp_err [NUM_TILES];
	logic [ACC_W-1:0] exp_idl [NUM_TILES];
	logic [LAT_W-1:0] exp_lat [NUM_TILES];

	logic [NUM_TILES-1:0] chk_tile;
	logic                 chk_stat_low;
	logic                 chk_en_off;
	int                   errors;
	integer               seed;
	string                test_name;

	initial clk_reg = 1'b0;
	always #10 clk_reg = ~clk_reg;

	initial clk_aie = 1'b0;
	always #(AIE_PERIOD / 2.0) clk_aie = ~clk_aie;

	stat_collector_top stat_collector_top_i (
		.clk_reg      (clk_reg),
		.rst_n        (rst_n),
		.test_en_reg  (test_en_reg),
		.smp_reg      (smp_reg),
		.err_reg      (err_reg),
		.idl_reg      (idl_reg),
		.lat_reg      (lat_reg),
		.done_stat_reg(done_stat_reg),
		.clk_aie      (clk_aie),
		.vld_aie      (vld_aie),
		.smp_aie      (smp_aie),
		.err_aie      (err_aie),
		.idl_aie      (idl_aie),
		.lat_aie      (lat_aie),
		.done_aie     (done_aie),
		.test_en_aie  (test_en_aie)
	);

	task automatic report_mismatch(input string what, input logic [ACC_W-1:0] exp,
			input logic [ACC_W-1:0] act);
		errors++;
		$display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, exp, act);
	endtask

	//----------------------------------------------------------
	// Checks
	//----------------------------------------------------------
	for (genvar t = 0; t < NUM_TILES; t++) begin : g_chk
		a_smp: assert property (@(posedge clk_reg) chk_tile[t] |-> smp_reg[t] == exp_smp[t])
			else report_mismatch($sformatf("smp_reg[%0d]", t), $sampled(exp_smp[t]),
				$sampled(smp_reg[t]));
		a_err: assert property (@(posedge clk_reg) chk_tile[t] |-> err_reg[t] == exp_err[t])
			else report_mismatch($sformatf("err_reg[%0d]", t), $sampled(exp_err[t]),
				$sampled(err_reg[t]));
		a_idl: assert property (@(posedge clk_reg) chk_tile[t] |-> idl_reg[t] == exp_idl[t])
			else report_mismatch($sformatf("idl_reg[%0d]", t), $sampled(exp_idl[t]),
				$sampled(idl_reg[t]));
		a_lat: assert property (@(posedge clk_reg) chk_tile[t] |-> lat_reg[t] == exp_lat[t])
			else report_mismatch($sformatf("lat_reg[%0d]", t), $sampled(exp_lat[t]),
				$sampled(lat_reg[t]));
	end

	a_stat_low: assert property (@(posedge clk_reg) chk_stat_low |-> !done_stat_reg)
		else report_mismatch("done_stat_reg", 0, 1);

	a_en_off: assert property (@(posedge clk_aie) chk_en_off |-> !test_en_aie)
		else report_mismatch("test_en_aie", 0, 1);

	//----------------------------------------------------------
	// Stimulus helpers
	//----------------------------------------------------------
	task automatic clear_model();
		for (int t = 0; t < NUM_TILES; t++) begin
			sum_smp[t] = '0;
			sum_err[t] = '0;
			sum_idl[t] = '0;
			sum_lat[t] = '0;
			exp_smp[t] = '0;
			exp_err[t] = '0;
			exp_idl[t] = '0;
			exp_lat[t] = '0;
		end
	endtask

	// Results of the tiles in mask are now expected on the register side
	task automatic publish(input logic [NUM_TILES-1:0] mask);
		for (int t = 0; t < NUM_TILES; t++) begin
			if (mask[t]) begin
				exp_smp[t] = sum_smp[t];
				exp_err[t] = sum_err[t];
				exp_idl[t] = sum_idl[t];
				exp_lat[t] = sum_lat[t];
			end
		end
	endtask

	task automatic drive_beats(input int n, input bit counted);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_aie);
			for (int t = 0; t < NUM_TILES; t++) begin
				vld_aie[t] = counted ? 1'($random(seed)) : 1'b1;
				smp_aie[t] = SMP_W'($random(seed));
				err_aie[t] = SMP_W'($random(seed));
				idl_aie[t] = IDL_W'($random(seed));
				lat_aie[t] = LAT_W'($random(seed));
				if (counted && vld_aie[t]) begin
					sum_smp[t] = sum_smp[t] + ACC_W'(smp_aie[t]);
					sum_err[t] = sum_err[t] + ACC_W'(err_aie[t]);
					sum_idl[t] = sum_idl[t] + ACC_W'(idl_aie[t]);
					if (lat_aie[t] > sum_lat[t])
						sum_lat[t] = lat_aie[t];
				end
			end
		end
		@(negedge clk_aie);
		vld_aie = '0;
	endtask

	task automatic wait_tiles(input logic [NUM_TILES-1:0] mask);
		@(negedge clk_reg);
		while ((stat_collector_top_i.tile_done & mask) != mask)
			@(negedge clk_reg);
	endtask

	task automatic start_run();
		@(negedge clk_reg);
		test_en_reg  = 1'b1;
		chk_tile     = '0;
		chk_stat_low = 1'b0;
		chk_en_off   = 1'b0;
		repeat (2) @(negedge clk_reg);  // Results clear, then done_stat_reg falls
		clear_model();
		chk_tile     = '1;
		chk_stat_low = 1'b1;
		while (!test_en_aie)
			@(negedge clk_aie);
		@(negedge clk_aie);
	endtask

	// Beats after the enable drops must be missing from the transferred totals
	task automatic stop_run();
		@(negedge clk_reg);
		test_en_reg = 1'b0;
		while (test_en_aie)
			@(negedge clk_aie);
		chk_en_off = 1'b1;
		drive_beats(NOISE, 1'b0);
	endtask

	// Tiles in late raise done only after the others have reported
	task automatic finish_run(input logic [NUM_TILES-1:0] late);
		chk_tile     = late;
		chk_stat_low = (late != '0);
		@(negedge clk_aie);
		done_aie = ~late;
		wait_tiles(~late);
		publish(~late);
		chk_tile = '1;
		if (late != '0) begin
			repeat (20) @(negedge clk_reg);
			chk_tile     = ~late;
			chk_stat_low = 1'b0;
			@(negedge clk_aie);
			done_aie = '1;
			wait_tiles('1);
			publish('1);
			chk_tile = '1;
		end
		while (!done_stat_reg)
			@(negedge clk_reg);
		repeat (10) @(negedge clk_reg);
	endtask

	//----------------------------------------------------------
	// Main sequence
	//----------------------------------------------------------
	initial begin
		int late_tile;
		seed         = 32'hcd63_be44;
		errors       = 0;
		test_name    = "reset";
		rst_n        = 1'b0;
		test_en_reg  = 1'b0;
		vld_aie      = '0;
		smp_aie      = '0;
		err_aie      = '0;
		idl_aie      = '0;
		lat_aie      = '0;
		done_aie     = '0;
		chk_tile     = '0;
		chk_stat_low = 1'b0;
		chk_en_off   = 1'b0;
		clear_model();
		repeat (16) @(negedge clk_reg);
		rst_n        = 1'b1;
		chk_tile     = '1;
		chk_stat_low = 1'b1;
		chk_en_off   = 1'b1;

		test_name = "run 1";
		late_tile = $unsigned($random(seed)) % NUM_TILES;
		start_run();
		drive_beats(BEATS, 1'b1);
		stop_run();
		finish_run(NUM_TILES'(1) << late_tile);

		test_name = "restart";
		@(negedge clk_aie);
		done_aie = '0;

		test_name = "run 2";
		start_run();
		drive_beats(BEATS, 1'b1);
		stop_run();
		finish_run('0);

		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(NUM_RUNS * (BEATS + 200) * AIE_PERIOD);
		$display("Watchdog expired, the DUT did not report done in time");
		$display("Checks finished with %0d errors", errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- tile_accum.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Per-tile statistics in clk_aie, no back-pressure on beats
// Beats count only while test_en_aie is high
// A rising test_en_aie clears all totals and drops that cycle's beat
//----------------------------------------------------------

module tile_accum import stat_pkg::*; (
	input  logic             clk_aie,
	input  logic             rst_n_aie,
	input  logic             test_en_aie,
	input  logic             vld,
	input  logic [SMP_W-1:0] smp,
	input  logic [SMP_W-1:0] err,
	input  logic [IDL_W-1:0] idl,
	input  logic [LAT_W-1:0] lat,
	output logic [ACC_W-1:0] smp_tot,
	output logic [ACC_W-1:0] err_tot,
	output logic [ACC_W-1:0] idl_tot,
	output logic [LAT_W-1:0] lat_max
);

	logic en_q;
	logic clr;
	logic acc_en;

	assign clr    = test_en_aie & ~en_q;  // Start of a new run
	assign acc_en = test_en_aie & vld;

	always_ff @(posedge clk_aie) begin
		if (!rst_n_aie) begin
			en_q <= 1'b0;
		end else begin
			en_q <= test_en_aie;
		end
	end

	//----------------------------------------------------------
	// Accumulators
	//----------------------------------------------------------
	always_ff @(posedge clk_aie) begin
		if (!rst_n_aie || clr) begin
			smp_tot <= '0;
			err_tot <= '0;
			idl_tot <= '0;
			lat_max <= '0;
		end else if (acc_en) begin
			smp_tot <= smp_tot + ACC_W'(smp);
			err_tot <= err_tot + ACC_W'(err);
			idl_tot <= idl_tot + ACC_W'(idl);
			if (lat > lat_max) begin
				lat_max <= lat;
			end
		end
	end

	// Within a run no total goes down
	a_no_decrease: assert property (@(posedge clk_aie) disable iff (!rst_n_aie)
		rst_n_aie && !clr |=>
			smp_tot >= $past(smp_tot) && err_tot >= $past(err_tot) &&
			idl_tot >= $past(idl_tot) && lat_max >= $past(lat_max));

endmodule

//--- xfer_fsm.sv
`timescale 1ns/1ps
//----------------------------------------------------------
// Source side of the four-phase result transfer, in clk_aie
// done is taken only in idle, so a second done mid-transfer is lost
// Totals must be stable when done rises
//----------------------------------------------------------

module xfer_fsm import stat_pkg::*; (
	input  logic             clk_aie,
	input  logic             rst_n_aie,
	input  logic             done,
	input  logic             ack,
	input  logic [ACC_W-1:0] smp_tot,
	input  logic [ACC_W-1:0] err_tot,
	input  logic [ACC_W-1:0] idl_tot,
	input  logic [LAT_W-1:0] lat_max,
	output logic [ACC_W-1:0] snap_smp,
	output logic [ACC_W-1:0] snap_err,
	output logic [ACC_W-1:0] snap_idl,
	output logic [LAT_W-1:0] snap_lat,
	output logic             req
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CAPTURE,
		ST_REQ_HIGH,
		ST_WAIT_LOW
	} state_t;

	state_t state;
	logic   done_q;
	logic   ack_s;

	bit_sync ack_sync_i (.clk(clk_aie), .rst_n(rst_n_aie), .d(ack), .q(ack_s));

	always_ff @(posedge clk_aie) begin
		if (!rst_n_aie) begin
			state  <= ST_IDLE;
			req    <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= done;
			case (state)
				ST_IDLE: begin
					if (done && !done_q) begin
						state <= ST_CAPTURE;
					end
				end
				ST_CAPTURE: state <= ST_REQ_HIGH;
				ST_REQ_HIGH: begin
					if (ack_s) begin
						req   <= 1'b0;
						state <= ST_WAIT_LOW;
					end else begin
						req <= 1'b1;  // One cycle after the snapshot
					end
				end
				ST_WAIT_LOW: begin
					if (!ack_s) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Snapshot bus crosses to clk_reg unsynchronized, qualified by req
	always_ff @(posedge clk_aie) begin
		if (state == ST_CAPTURE) begin
			snap_smp <= smp_tot;
			snap_err <= err_tot;
			snap_idl <= idl_tot;
			snap_lat <= lat_max;
		end
	end

	a_req_until_ack: assert property (@(posedge clk_aie) disable iff (!rst_n_aie)
		state == ST_REQ_HIGH && req && !ack_s |=> req);

	a_snap_stable: assert property (@(posedge clk_aie) disable iff (!rst_n_aie)
		req |=> $stable({snap_smp, snap_err, snap_idl, snap_lat}));

endmodule
